/* verilog/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    localparam int XLEN = 32;                   // RV32I data word width

    // Major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP     = 7'b0110011,                // Register-register ALU
        OPC_OPIMM  = 7'b0010011,                // Register-immediate ALU
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_JAL    = 7'b1101111,                // Decoded, retires as no-op
        OPC_JALR   = 7'b1100111,                // Decoded, retires as no-op
        OPC_BRANCH = 7'b1100011                 // Decoded, retires as no-op
    } opcode_e;

    // ALU functions
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,                                // Signed compare
        ALU_SLTU,                               // Unsigned compare
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B                              // Forward operand B, LUI
    } alu_op_e;

endpackage

`default_nettype wire

/* verilog/rv32i_decoder.sv */
`default_nettype none

module rv32i_decoder #(
    parameter int REG_WIDTH = 5
) (
    input  wire logic [31:0]              i_inst,     // Instruction word
    output rv32i_pkg::opcode_e            o_opcode,   // Major opcode
    output logic [REG_WIDTH-1:0]          o_rs1,      // Source register 1
    output logic [REG_WIDTH-1:0]          o_rs2,      // Source register 2
    output logic [REG_WIDTH-1:0]          o_rd,       // Destination register
    output logic [rv32i_pkg::XLEN-1:0]    o_imm,      // Immediate, any format
    output rv32i_pkg::alu_op_e            o_alu_op,   // ALU function
    output logic                          o_is_load,  // LW
    output logic                          o_is_store, // SW
    output logic                          o_is_alu,   // OP or OP-IMM
    output logic                          o_use_imm,  // Operand B is immediate
    output logic                          o_use_pc    // Operand A is pc
);

    import rv32i_pkg::*;

    logic [2:0] funct3;
    logic       bit30;                          // SUB and SRA selector

    assign funct3   = i_inst[14:12];
    assign bit30    = i_inst[30];
    assign o_opcode = opcode_e'(i_inst[6:0]);   // Unknown codes pass as-is

    // Register fields, upper index bit dropped for small variants
    assign o_rs1 = i_inst[REG_WIDTH+14:15];
    assign o_rs2 = i_inst[REG_WIDTH+19:20];
    assign o_rd  = i_inst[REG_WIDTH+6:7];

    // Immediate for every format
    always_comb begin
        case (o_opcode)
            OPC_LUI, OPC_AUIPC: o_imm = {i_inst[31:12], 12'b0};              // U-type
            OPC_JAL:    o_imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20],
                                 i_inst[30:21], 1'b0};                        // J-type
            OPC_BRANCH: o_imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25],
                                 i_inst[11:8], 1'b0};                         // B-type
            OPC_LOAD:   o_imm = {{20{i_inst[31]}}, i_inst[31:20]};           // I-type
            OPC_STORE:  o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            OPC_JALR:   o_imm = (funct3 == 3'b000) ? {{20{i_inst[31]}}, i_inst[31:20]} : '0;
            OPC_OPIMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101)
                    o_imm = {27'b0, i_inst[24:20]};                           // Shamt, unsigned
                else
                    o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
            end
            default:    o_imm = '0;
        endcase
    end

    // ALU function from funct3 and funct7
    always_comb begin
        o_alu_op = ALU_ADD;                     // AUIPC, loads, stores
        if (o_opcode == OPC_LUI) begin
            o_alu_op = ALU_PASS_B;
        end else if (o_opcode == OPC_OP || o_opcode == OPC_OPIMM) begin
            case (funct3)
                3'b000:  o_alu_op = (o_opcode == OPC_OP && bit30) ? ALU_SUB : ALU_ADD;
                3'b001:  o_alu_op = ALU_SLL;
                3'b010:  o_alu_op = ALU_SLT;
                3'b011:  o_alu_op = ALU_SLTU;
                3'b100:  o_alu_op = ALU_XOR;
                3'b101:  o_alu_op = bit30 ? ALU_SRA : ALU_SRL;   // SRA and SRAI
                3'b110:  o_alu_op = ALU_OR;
                default: o_alu_op = ALU_AND;
            endcase
        end
    end

    // Instruction class flags
    assign o_is_load  = (o_opcode == OPC_LOAD);
    assign o_is_store = (o_opcode == OPC_STORE);
    assign o_is_alu   = (o_opcode == OPC_OP) || (o_opcode == OPC_OPIMM);
    assign o_use_pc   = (o_opcode == OPC_AUIPC);
    assign o_use_imm  = (o_opcode == OPC_OPIMM) || (o_opcode == OPC_LUI) ||
                        (o_opcode == OPC_AUIPC) || o_is_load || o_is_store;

endmodule

`default_nettype wire

/* verilog/rv32i_alu.sv */
`default_nettype none

module rv32i_alu (
    input  wire logic [rv32i_pkg::XLEN-1:0] i_a,       // Operand A
    input  wire logic [rv32i_pkg::XLEN-1:0] i_b,       // Operand B
    input  wire rv32i_pkg::alu_op_e         i_op,      // Function
    output logic [rv32i_pkg::XLEN-1:0]      o_result   // Result
);

    import rv32i_pkg::*;

    logic [4:0] shamt;

    assign shamt = i_b[4:0];                    // Low five bits only

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, i_a < i_b};
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SRL:    o_result = i_a >> shamt;
            ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);   // Sign fill
            ALU_OR:     o_result = i_a | i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv32i_regfile.sv */
`default_nettype none

module rv32i_regfile #(
    parameter int REG_WIDTH = 5
) (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst,
    input  wire logic [REG_WIDTH-1:0]        i_raddr1,  // Read port 1 index
    input  wire logic [REG_WIDTH-1:0]        i_raddr2,  // Read port 2 index
    input  wire logic                        i_we,      // Write enable
    input  wire logic [REG_WIDTH-1:0]        i_waddr,   // Write index
    input  wire logic [rv32i_pkg::XLEN-1:0]  i_wdata,   // Write data
    output logic [rv32i_pkg::XLEN-1:0]       o_rdata1,
    output logic [rv32i_pkg::XLEN-1:0]       o_rdata2
);

    import rv32i_pkg::*;

    logic [XLEN-1:0] regs [2**REG_WIDTH];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2**REG_WIDTH; i++)
                regs[i] <= '0;                  // Clear whole file
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;           // x0 never written
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

/* verilog/rv32i_issue_stage.sv */
`default_nettype none

module rv32i_issue_stage #(
    parameter int REG_WIDTH = 5
) (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst,
    input  wire logic                        i_inst_valid, // Instruction strobe
    input  wire logic [31:0]                 i_inst,       // Instruction word
    output logic                             o_valid,
    output logic [rv32i_pkg::XLEN-1:0]       o_pc,         // Pc of this instruction
    output logic [REG_WIDTH-1:0]             o_rs1,
    output logic [REG_WIDTH-1:0]             o_rs2,
    output logic [REG_WIDTH-1:0]             o_rd,
    output logic [rv32i_pkg::XLEN-1:0]       o_imm,
    output rv32i_pkg::alu_op_e               o_alu_op,
    output logic                             o_use_imm,
    output logic                             o_use_pc,
    output logic                             o_is_load,
    output logic                             o_is_store,
    output logic                             o_writes_rd   // Retires with writeback
);

    import rv32i_pkg::*;

    logic [XLEN-1:0]      pc;                   // Next pc to assign
    opcode_e              dec_opcode;
    logic [REG_WIDTH-1:0] dec_rs1, dec_rs2, dec_rd;
    logic [XLEN-1:0]      dec_imm;
    alu_op_e              dec_alu_op;
    logic                 dec_is_load, dec_is_store, dec_is_alu;
    logic                 dec_use_imm, dec_use_pc;
    logic                 dec_writes_rd;

    rv32i_decoder #(
        .REG_WIDTH (REG_WIDTH)
    ) i_rv32i_decoder (
        .i_inst     (i_inst),
        .o_opcode   (dec_opcode),
        .o_rs1      (dec_rs1),
        .o_rs2      (dec_rs2),
        .o_rd       (dec_rd),
        .o_imm      (dec_imm),
        .o_alu_op   (dec_alu_op),
        .o_is_load  (dec_is_load),
        .o_is_store (dec_is_store),
        .o_is_alu   (dec_is_alu),
        .o_use_imm  (dec_use_imm),
        .o_use_pc   (dec_use_pc)
    );

    // Only instructions that produce a register result, never x0
    assign dec_writes_rd = (dec_is_alu || dec_is_load || dec_opcode == OPC_LUI ||
                            dec_opcode == OPC_AUIPC) && (dec_rd != '0);

    // Control, cleared on reset and gated by the strobe
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc          <= '0;
            o_valid     <= 1'b0;
            o_is_load   <= 1'b0;
            o_is_store  <= 1'b0;
            o_writes_rd <= 1'b0;
        end else begin
            if (i_inst_valid)
                pc <= pc + XLEN'(4);            // Every accepted instruction
            o_valid     <= i_inst_valid;
            o_is_load   <= i_inst_valid & dec_is_load;
            o_is_store  <= i_inst_valid & dec_is_store;
            o_writes_rd <= i_inst_valid & dec_writes_rd;
        end
    end

    // Payload
    always_ff @(posedge i_clk) begin
        o_pc      <= pc;
        o_rs1     <= dec_rs1;
        o_rs2     <= dec_rs2;
        o_rd      <= dec_rd;
        o_imm     <= dec_imm;
        o_alu_op  <= dec_alu_op;
        o_use_imm <= dec_use_imm;
        o_use_pc  <= dec_use_pc;
    end

endmodule

`default_nettype wire

/* verilog/rv32i_execute_stage.sv */
`default_nettype none

module rv32i_execute_stage #(
    parameter int REG_WIDTH = 5
) (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst,
    input  wire logic                        i_valid,
    input  wire logic [rv32i_pkg::XLEN-1:0]  i_pc,
    input  wire logic [REG_WIDTH-1:0]        i_rs1,
    input  wire logic [REG_WIDTH-1:0]        i_rs2,
    input  wire logic [REG_WIDTH-1:0]        i_rd,
    input  wire logic [rv32i_pkg::XLEN-1:0]  i_imm,
    input  wire rv32i_pkg::alu_op_e          i_alu_op,
    input  wire logic                        i_use_imm,
    input  wire logic                        i_use_pc,
    input  wire logic                        i_is_load,
    input  wire logic                        i_is_store,
    input  wire logic                        i_writes_rd,
    output logic [REG_WIDTH-1:0]             o_raddr1,     // Register file reads
    output logic [REG_WIDTH-1:0]             o_raddr2,
    input  wire logic [rv32i_pkg::XLEN-1:0]  i_rdata1,
    input  wire logic [rv32i_pkg::XLEN-1:0]  i_rdata2,
    input  wire logic                        i_fwd_valid,  // Bypass from memory stage
    input  wire logic [REG_WIDTH-1:0]        i_fwd_rd,
    input  wire logic [rv32i_pkg::XLEN-1:0]  i_fwd_data,
    output logic                             o_valid,
    output logic [REG_WIDTH-1:0]             o_rd,
    output logic [rv32i_pkg::XLEN-1:0]       o_result,     // Also the memory address
    output logic [rv32i_pkg::XLEN-1:0]       o_store_data,
    output logic                             o_is_load,
    output logic                             o_is_store,
    output logic                             o_writes_rd
);

    import rv32i_pkg::*;

    logic [XLEN-1:0] src1, src2;                // Newest register values
    logic [XLEN-1:0] op_a, op_b;
    logic [XLEN-1:0] alu_result;

    assign o_raddr1 = i_rs1;
    assign o_raddr2 = i_rs2;

    // Bypass wins on a nonzero index match
    assign src1 = (i_fwd_valid && i_rs1 != '0 && i_fwd_rd == i_rs1) ? i_fwd_data : i_rdata1;
    assign src2 = (i_fwd_valid && i_rs2 != '0 && i_fwd_rd == i_rs2) ? i_fwd_data : i_rdata2;

    assign op_a = i_use_pc  ? i_pc  : src1;     // AUIPC
    assign op_b = i_use_imm ? i_imm : src2;

    rv32i_alu i_rv32i_alu (
        .i_a      (op_a),
        .i_b      (op_b),
        .i_op     (i_alu_op),
        .o_result (alu_result)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid     <= 1'b0;
            o_is_load   <= 1'b0;
            o_is_store  <= 1'b0;
            o_writes_rd <= 1'b0;
        end else begin
            o_valid     <= i_valid;
            o_is_load   <= i_is_load;
            o_is_store  <= i_is_store;
            o_writes_rd <= i_writes_rd;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rd         <= i_rd;
        o_result     <= alu_result;
        o_store_data <= src2;                   // Bypassed rs2
    end

endmodule

`default_nettype wire

/* verilog/rv32i_memory_stage.sv */
`default_nettype none

module rv32i_memory_stage #(
    parameter int REG_WIDTH  = 5,
    parameter int DMEM_WORDS = 64
) (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst,
    input  wire logic                        i_valid,
    input  wire logic [REG_WIDTH-1:0]        i_rd,
    input  wire logic [rv32i_pkg::XLEN-1:0]  i_result,     // ALU result or address
    input  wire logic [rv32i_pkg::XLEN-1:0]  i_store_data,
    input  wire logic                        i_is_load,
    input  wire logic                        i_is_store,
    input  wire logic                        i_writes_rd,
    output logic                             o_fwd_valid,  // Bypass and regfile write
    output logic [REG_WIDTH-1:0]             o_fwd_rd,
    output logic [rv32i_pkg::XLEN-1:0]       o_fwd_data,
    output logic                             o_wb_valid,   // Writeback report
    output logic [REG_WIDTH-1:0]             o_wb_rd,
    output logic [rv32i_pkg::XLEN-1:0]       o_wb_data
);

    import rv32i_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [AW-1:0]   word_idx;

    assign word_idx = i_result[AW+1:2];         // Byte offset dropped, wraps

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (i_valid && i_is_store) begin
            dmem[word_idx] <= i_store_data;     // Whole word
        end
    end

    // Final value, load data read asynchronously
    assign o_fwd_valid = i_valid & i_writes_rd;
    assign o_fwd_rd    = i_rd;
    assign o_fwd_data  = i_is_load ? dmem[word_idx] : i_result;

    always_ff @(posedge i_clk) begin
        if (i_rst)
            o_wb_valid <= 1'b0;
        else
            o_wb_valid <= o_fwd_valid;
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd   <= o_fwd_rd;
        o_wb_data <= o_fwd_data;
    end

endmodule

`default_nettype wire

/* verilog/rv32i_int_pipe.sv */
`default_nettype none

module rv32i_int_pipe #(
    parameter int REG_WIDTH  = 5,               // 4 for a 16-register variant
    parameter int DMEM_WORDS = 64               // Power of two
) (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst,
    input  wire logic                        i_inst_valid,
    input  wire logic [31:0]                 i_inst,
    output logic                             o_wb_valid,
    output logic [REG_WIDTH-1:0]             o_wb_rd,
    output logic [rv32i_pkg::XLEN-1:0]       o_wb_data
);

    import rv32i_pkg::*;

    // Issue to execute
    logic                 s1_valid, s1_use_imm, s1_use_pc;
    logic                 s1_is_load, s1_is_store, s1_writes_rd;
    logic [XLEN-1:0]      s1_pc, s1_imm;
    logic [REG_WIDTH-1:0] s1_rs1, s1_rs2, s1_rd;
    alu_op_e              s1_alu_op;
    // Execute to memory
    logic                 s2_valid, s2_is_load, s2_is_store, s2_writes_rd;
    logic [REG_WIDTH-1:0] s2_rd;
    logic [XLEN-1:0]      s2_result, s2_store_data;
    // Register file and bypass
    logic [REG_WIDTH-1:0] rf_raddr1, rf_raddr2;
    logic [XLEN-1:0]      rf_rdata1, rf_rdata2;
    logic                 m_fwd_valid;
    logic [REG_WIDTH-1:0] m_fwd_rd;
    logic [XLEN-1:0]      m_fwd_data;

    rv32i_issue_stage #(
        .REG_WIDTH (REG_WIDTH)
    ) i_rv32i_issue_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .o_valid      (s1_valid),
        .o_pc         (s1_pc),
        .o_rs1        (s1_rs1),
        .o_rs2        (s1_rs2),
        .o_rd         (s1_rd),
        .o_imm        (s1_imm),
        .o_alu_op     (s1_alu_op),
        .o_use_imm    (s1_use_imm),
        .o_use_pc     (s1_use_pc),
        .o_is_load    (s1_is_load),
        .o_is_store   (s1_is_store),
        .o_writes_rd  (s1_writes_rd)
    );

    rv32i_execute_stage #(
        .REG_WIDTH (REG_WIDTH)
    ) i_rv32i_execute_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (s1_valid),
        .i_pc         (s1_pc),
        .i_rs1        (s1_rs1),
        .i_rs2        (s1_rs2),
        .i_rd         (s1_rd),
        .i_imm        (s1_imm),
        .i_alu_op     (s1_alu_op),
        .i_use_imm    (s1_use_imm),
        .i_use_pc     (s1_use_pc),
        .i_is_load    (s1_is_load),
        .i_is_store   (s1_is_store),
        .i_writes_rd  (s1_writes_rd),
        .o_raddr1     (rf_raddr1),
        .o_raddr2     (rf_raddr2),
        .i_rdata1     (rf_rdata1),
        .i_rdata2     (rf_rdata2),
        .i_fwd_valid  (m_fwd_valid),
        .i_fwd_rd     (m_fwd_rd),
        .i_fwd_data   (m_fwd_data),
        .o_valid      (s2_valid),
        .o_rd         (s2_rd),
        .o_result     (s2_result),
        .o_store_data (s2_store_data),
        .o_is_load    (s2_is_load),
        .o_is_store   (s2_is_store),
        .o_writes_rd  (s2_writes_rd)
    );

    rv32i_memory_stage #(
        .REG_WIDTH  (REG_WIDTH),
        .DMEM_WORDS (DMEM_WORDS)
    ) i_rv32i_memory_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (s2_valid),
        .i_rd         (s2_rd),
        .i_result     (s2_result),
        .i_store_data (s2_store_data),
        .i_is_load    (s2_is_load),
        .i_is_store   (s2_is_store),
        .i_writes_rd  (s2_writes_rd),
        .o_fwd_valid  (m_fwd_valid),
        .o_fwd_rd     (m_fwd_rd),
        .o_fwd_data   (m_fwd_data),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

    rv32i_regfile #(
        .REG_WIDTH (REG_WIDTH)
    ) i_rv32i_regfile (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_raddr1 (rf_raddr1),
        .i_raddr2 (rf_raddr2),
        .i_we     (m_fwd_valid),                // Same edge as writeback register
        .i_waddr  (m_fwd_rd),
        .i_wdata  (m_fwd_data),
        .o_rdata1 (rf_rdata1),
        .o_rdata2 (rf_rdata2)
    );

endmodule

`default_nettype wire

/* dv/rv32i_int_pipe_tb.sv */
`default_nettype none

module rv32i_int_pipe_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int REG_WIDTH  = 5;
    localparam int DMEM_WORDS = 64;
    localparam int K_OP    = 0;                 // Instruction kinds for the generator
    localparam int K_OPIMM = 1;
    localparam int K_LUI   = 2;
    localparam int K_AUIPC = 3;
    localparam int K_LW    = 4;
    localparam int K_SW    = 5;
    localparam int K_BAD   = 6;                 // Unsupported opcode

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_inst_valid;
    logic [31:0]          i_inst;
    logic                 o_wb_valid;
    logic [REG_WIDTH-1:0] o_wb_rd;
    logic [31:0]          o_wb_data;

    logic [31:0] rng_state;                     // Xorshift state
    logic [31:0] ref_regs [32];                 // Architectural registers
    logic [31:0] ref_mem [DMEM_WORDS];          // Data memory by word index
    logic [31:0] ref_pc;
    logic [4:0]  recent [4];                    // Recently written registers
    logic [1:0]  recent_ptr;
    int          exp_cyc [$];                   // Cycle the writeback is due
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          cyc = 0;
    int          checked = 0;
    int          val_errs = 0;
    int          other_errs = 0;
    int          timeout_errs = 0;

    rv32i_int_pipe #(
        .REG_WIDTH  (REG_WIDTH),
        .DMEM_WORDS (DMEM_WORDS)
    ) i_rv32i_int_pipe (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;             // 100 ns period
    end

    always @(posedge i_clk) cyc <= cyc + 1;     // Edge count

    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I integer function by funct3, alt selects SUB and SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};  // Sign decides first
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt && a[31])
                    return (a >> b[4:0]) | ~(32'hFFFF_FFFF >> b[4:0]);  // Ones shifted in
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [6:0] bad_opcode(input logic [2:0] sel);
        case (sel)
            3'd0:    return 7'b1101111;         // JAL
            3'd1:    return 7'b1100111;         // JALR
            3'd2:    return 7'b1100011;         // Branch
            3'd3:    return 7'b0001111;         // Fence
            3'd4:    return 7'b1110011;         // System
            3'd5:    return 7'b0101111;         // Atomics
            3'd6:    return 7'b0000000;
            default: return 7'b1111111;
        endcase
    endfunction

    // Half the time a recent destination, to hit the bypass
    function automatic logic [4:0] pick_src();
        logic [31:0] r;
        r = rand_next();
        if (r[0])
            return recent[r[2:1]];
        return r[7:3];
    endfunction

    // Encode, run the model, then drive after the edge
    task automatic send_inst(input int kind, input logic [2:0] f3, input logic alt,
                             input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0] inst;
        logic [31:0] val;
        logic [31:0] addr;
        logic        wr;
        int          idx;
        val  = '0;
        wr   = 1'b1;
        addr = ref_regs[rs1] + sext12(imm[11:0]);
        idx  = int'((addr >> 2) % DMEM_WORDS);  // Word index wraps
        case (kind)
            K_OP: begin
                inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
                val  = alu_ref(f3, alt, ref_regs[rs1], ref_regs[rs2]);
            end
            K_OPIMM: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    inst = {1'b0, alt, 5'b0, imm[4:0], rs1, f3, rd, 7'b0010011};
                    val  = alu_ref(f3, alt, ref_regs[rs1], {27'b0, imm[4:0]});
                end else begin
                    inst = {imm[11:0], rs1, f3, rd, 7'b0010011};
                    val  = alu_ref(f3, 1'b0, ref_regs[rs1], sext12(imm[11:0]));
                end
            end
            K_LUI: begin
                inst = {imm[31:12], rd, 7'b0110111};
                val  = {imm[31:12], 12'b0};
            end
            K_AUIPC: begin
                inst = {imm[31:12], rd, 7'b0010111};
                val  = ref_pc + {imm[31:12], 12'b0};
            end
            K_LW: begin
                inst = {imm[11:0], rs1, f3, rd, 7'b0000011};   // funct3 has no effect
                val  = ref_mem[idx];
            end
            K_SW: begin
                inst = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
                ref_mem[idx] = ref_regs[rs2];
                wr   = 1'b0;
            end
            default: begin
                inst = {imm[24:0], bad_opcode(f3)};
                wr   = 1'b0;
            end
        endcase
        @(posedge i_clk);
        #10;
        i_inst_valid = 1'b1;
        i_inst       = inst;
        if (wr && rd != 5'd0) begin
            exp_cyc.push_back(cyc + 3);         // Sampled next edge, out two edges later
            exp_rd.push_back(rd);
            exp_data.push_back(val);
            ref_regs[rd] = val;
            recent[recent_ptr] = rd;
            recent_ptr++;
        end
        ref_pc = ref_pc + 32'd4;                // Every accepted instruction
    endtask

    task automatic idle_cycle();
        @(posedge i_clk);
        #10;
        i_inst_valid = 1'b0;
        i_inst       = rand_next();             // Garbage while the strobe is low
    endtask

    task automatic random_inst();
        logic [31:0] r;
        logic [31:0] imm;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        int          kind;
        r   = rand_next();
        imm = rand_next();
        f3  = r[6:4];
        alt = r[7] && (f3 == 3'd0 || f3 == 3'd5);
        rd  = (r[10:8] == 3'd0) ? 5'd0 : r[15:11];      // Some x0 destinations
        rs1 = pick_src();
        rs2 = pick_src();
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3:  kind = K_OP;
            4'd4, 4'd5, 4'd6, 4'd7:  kind = K_OPIMM;
            4'd8:                    kind = K_LUI;
            4'd9:                    kind = K_AUIPC;
            4'd10, 4'd11:            kind = K_LW;
            4'd12, 4'd13:            kind = K_SW;
            4'd14:                   kind = K_BAD;
            default:                 kind = K_OPIMM;
        endcase
        if (kind == K_LW || kind == K_SW) begin
            imm = {21'b0, imm[10:0]};           // Eight aliases of the memory
            if (r[17:16] != 2'd0)
                rs1 = 5'd0;                     // Mostly absolute addresses
        end
        send_inst(kind, f3, alt, rd, rs1, rs2, imm);
    endtask

    // Writeback compare, mid-cycle where outputs are stable
    always @(negedge i_clk) begin : wb_check
        logic        due;
        logic [4:0]  rd_exp;
        logic [31:0] data_exp;
        due = 1'b0;
        if (exp_cyc.size() > 0)
            due = (exp_cyc[0] == cyc);
        if (due) begin
            void'(exp_cyc.pop_front());
            rd_exp   = exp_rd.pop_front();
            data_exp = exp_data.pop_front();
            checked++;
            assert (o_wb_valid === 1'b1) else begin
                val_errs++;
                $display("error o_wb_valid: expected 1, actual %h", o_wb_valid);
            end
            assert (o_wb_rd === rd_exp) else begin
                val_errs++;
                $display("error o_wb_rd: expected %h, actual %h", rd_exp, o_wb_rd);
            end
            assert (o_wb_data === data_exp) else begin
                val_errs++;
                $display("error o_wb_data: expected %h, actual %h", data_exp, o_wb_data);
            end
        end else if (!i_rst) begin
            assert (o_wb_valid === 1'b0) else begin
                other_errs++;
                $display("Writeback to x%0d in cycle %0d with no instruction due", o_wb_rd, cyc);
            end
        end
    end

    initial begin
        int n;
        int wait_cnt;
        i_rst        = 1'b1;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        rng_state    = 32'd59429;
        ref_pc       = '0;
        recent_ptr   = '0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            ref_mem[i] = '0;
        for (int i = 0; i < 4; i++)
            recent[i] = 5'(i + 1);
        repeat (2) @(posedge i_clk);
        #10;
        i_rst = 1'b0;

        send_inst(K_OPIMM, 3'd0, 1'b0, 5'd1, 5'd0, 5'd0, 32'hFFB);      // x1 = -5
        send_inst(K_OPIMM, 3'd0, 1'b0, 5'd2, 5'd0, 5'd0, 32'd3);
        send_inst(K_OP,    3'd0, 1'b1, 5'd3, 5'd1, 5'd2, 32'd0);        // Sub, x2 from the bypass
        send_inst(K_OP,    3'd2, 1'b0, 5'd4, 5'd1, 5'd2, 32'd0);        // Signed compare
        send_inst(K_OP,    3'd3, 1'b0, 5'd5, 5'd1, 5'd2, 32'd0);        // Unsigned compare
        send_inst(K_OP,    3'd5, 1'b1, 5'd6, 5'd1, 5'd2, 32'd0);        // SRA of a negative
        send_inst(K_OPIMM, 3'd5, 1'b1, 5'd7, 5'd1, 5'd0, 32'd1);        // SRAI
        send_inst(K_OPIMM, 3'd5, 1'b0, 5'd8, 5'd1, 5'd0, 32'd4);        // SRLI
        send_inst(K_OPIMM, 3'd1, 1'b0, 5'd14, 5'd1, 5'd0, 32'd31);      // SLLI
        send_inst(K_LUI,   3'd0, 1'b0, 5'd9, 5'd0, 5'd0, 32'h12345000);
        send_inst(K_AUIPC, 3'd0, 1'b0, 5'd10, 5'd0, 5'd0, 32'hFFFFF000);
        send_inst(K_SW,    3'd2, 1'b0, 5'd0, 5'd0, 5'd9, 32'd8);        // Store x9 to word 2
        send_inst(K_LW,    3'd2, 1'b0, 5'd11, 5'd0, 5'd0, 32'd8);
        send_inst(K_OP,    3'd0, 1'b0, 5'd12, 5'd11, 5'd11, 32'd0);     // Load result used at once
        send_inst(K_SW,    3'd2, 1'b0, 5'd0, 5'd0, 5'd1, 32'd268);      // Aliases word 3
        send_inst(K_LW,    3'd2, 1'b0, 5'd13, 5'd0, 5'd0, 32'd12);
        send_inst(K_OPIMM, 3'd0, 1'b0, 5'd0, 5'd1, 5'd0, 32'd7);        // x0 destination
        send_inst(K_BAD,   3'd0, 1'b0, 5'd0, 5'd0, 5'd0, 32'h00000F80); // JAL
        idle_cycle();

        for (n = 0; n < 2000; n++) begin
            if (rand_next() % 6 == 0)
                idle_cycle();
            random_inst();
        end
        idle_cycle();

        wait_cnt = 0;
        while (exp_cyc.size() > 0 && wait_cnt < 10) begin
            @(posedge i_clk);
            wait_cnt++;
        end
        if (exp_cyc.size() > 0) begin
            timeout_errs++;
            $display("Timeout with %0d expected writebacks still missing", exp_cyc.size());
        end
        repeat (4) @(posedge i_clk);            // Watch for stray writebacks
        $display("Writebacks checked %0d, value errors %0d, stray writebacks %0d, timeouts %0d",
                 checked, val_errs, other_errs, timeout_errs);
        if (val_errs + other_errs + timeout_errs == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/rv32i_pkg.sv
verilog/rv32i_decoder.sv
verilog/rv32i_alu.sv
verilog/rv32i_regfile.sv
verilog/rv32i_issue_stage.sv
verilog/rv32i_execute_stage.sv
verilog/rv32i_memory_stage.sv
verilog/rv32i_int_pipe.sv
dv/rv32i_int_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the RV32I pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv32i_int_pipe_tb -Mdir obj_dir -f filelist.f
./obj_dir/Vrv32i_int_pipe_tb > sim.log 2>&1
cat sim.log
if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
